/* include/opl_consts.svh */
// OPL channel stage constants for bank, channel, operator and width counts
`ifndef OPL_CONSTS_SVH
`define OPL_CONSTS_SVH

// register banks, each with its own channel set
`define OPL_NUM_BANKS 2

`define OPL_CH_PER_BANK 9     // two-operator channels only
`define OPL_OP_PER_BANK 18    // two operators per channel

`define OPL_OP_WIDTH 13       // signed operator output
`define OPL_SAMPLE_WIDTH 16   // signed stereo sample

// headroom for 18 channels of summed operator pairs
`define OPL_ACC_WIDTH 20

// channel 0 connection and pan register, channel c sits at base + c
`define OPL_REG_CH_BASE 8'hC0

`endif

/* verilog/opl_pkg.sv */
// OPL channel stage package with the shared vector types, structs and mixer states
`include "opl_consts.svh"

package opl_pkg;

    typedef logic                                bank_t;
    typedef logic [4:0]                          op_idx_t;   // operator within a bank
    typedef logic [3:0]                          ch_idx_t;   // channel within a bank
    typedef logic signed [`OPL_OP_WIDTH-1:0]     op_out_t;
    typedef logic signed [`OPL_SAMPLE_WIDTH-1:0] sample_t;
    typedef logic signed [`OPL_ACC_WIDTH-1:0]    acc_t;
    typedef logic [7:0]                          reg_addr_t;
    typedef logic [7:0]                          reg_data_t;

    typedef struct packed {
        bank_t   bank;
        op_idx_t op_idx;
        op_out_t value;
    } op_result_t;

    typedef struct packed {
        logic      valid;
        bank_t     bank;
        reg_addr_t addr;
        reg_data_t data;
    } reg_wr_t;

    typedef struct packed {
        logic cnt;    // 1 = additive, 0 = second operator only
        logic pan_l;
        logic pan_r;
    } channel_cfg_t;

    typedef struct packed {
        sample_t left;
        sample_t right;
    } stereo_t;

    typedef enum logic [2:0] {
        IDLE,
        READ_SECOND,
        READ_FIRST,
        ACCUMULATE,
        CLAMP,
        SEND,
        WAIT_ACK_LOW
    } mixer_state_t;

endpackage

/* verilog/operator_capture.sv */
// Operator capture block that stores handshaked operator results and flags a full frame
`timescale 1ns/10ps
`include "opl_consts.svh"

module operator_capture (
    input  logic                clk,
    input  logic                rst,
    input  logic                op_req,
    input  opl_pkg::op_result_t op_result,
    output logic                op_ack,
    input  logic                mixer_busy,
    output logic                mem_we,
    output opl_pkg::bank_t      mem_bank,
    output opl_pkg::op_idx_t    mem_addr,
    output opl_pkg::op_out_t    mem_wdata,
    output logic                ops_done
);
    localparam int NUM_OPS = `OPL_NUM_BANKS * `OPL_OP_PER_BANK;
    localparam int IDX_W   = $clog2(NUM_OPS);

    logic [NUM_OPS-1:0] written;    // one bit per operator of the frame
    logic [IDX_W-1:0]   flat_idx;
    logic               frame_full;
    logic               accept;

    // bank 1 operators follow the 18 of bank 0
    assign flat_idx = op_result.bank ? IDX_W'(op_result.op_idx) + IDX_W'(`OPL_OP_PER_BANK)
                                     : IDX_W'(op_result.op_idx);

    assign frame_full = &written;
    // hold off while the mixer reads the frame
    assign accept     = op_req && !op_ack && !mixer_busy;

    assign mem_we    = accept;
    assign mem_bank  = op_result.bank;
    assign mem_addr  = op_result.op_idx;
    assign mem_wdata = op_result.value;

    always_ff @(posedge clk) begin
        if (rst) begin
            op_ack   <= 1'b0;
            ops_done <= 1'b0;
            written  <= '0;
        end else begin
            ops_done <= frame_full;    // one cycle pulse as the bitmap clears
            if (accept)
                op_ack <= 1'b1;
            else if (!op_req)
                op_ack <= 1'b0;
            if (frame_full)
                written <= '0;
            else if (accept)
                written[flat_idx] <= 1'b1;
        end
    end

    // an ack only follows a request seen while the mixer was idle
    a_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(op_ack) |-> $past(op_req && !mixer_busy));

endmodule

/* verilog/operator_out_mem.sv */
// Operator result memory, two banks of operator values with one write and one registered read port
`timescale 1ns/10ps
`include "opl_consts.svh"

module operator_out_mem (
    input  logic             clk,
    input  logic             we,
    input  opl_pkg::bank_t   wbank,
    input  opl_pkg::op_idx_t waddr,
    input  opl_pkg::op_out_t wdata,
    input  logic             re,
    input  opl_pkg::bank_t   rbank,
    input  opl_pkg::op_idx_t raddr,
    output opl_pkg::op_out_t rdata
);
    opl_pkg::op_out_t mem [`OPL_NUM_BANKS][`OPL_OP_PER_BANK];

    always_ff @(posedge clk) begin
        if (we)
            mem[wbank][waddr] <= wdata;
    end

    // one cycle read latency, output holds between reads
    always_ff @(posedge clk) begin
        if (re)
            rdata <= mem[rbank][raddr];
    end

endmodule

/* verilog/channel_regs.sv */
// Channel register file, decodes connection and pan writes and serves one channel's config
`timescale 1ns/10ps
`include "opl_consts.svh"

module channel_regs (
    input  logic                  clk,
    input  logic                  rst,
    input  opl_pkg::reg_wr_t      reg_wr,
    input  opl_pkg::bank_t        cfg_bank,
    input  opl_pkg::ch_idx_t      cfg_ch,
    output opl_pkg::channel_cfg_t cfg
);
    opl_pkg::channel_cfg_t regs [`OPL_NUM_BANKS][`OPL_CH_PER_BANK];
    opl_pkg::reg_addr_t    ch_off;
    logic                  hit;

    // addresses below the base wrap to large offsets and miss too
    assign ch_off = reg_wr.addr - `OPL_REG_CH_BASE;
    assign hit    = reg_wr.valid && (ch_off < `OPL_CH_PER_BANK);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int b = 0; b < `OPL_NUM_BANKS; b++) begin
                for (int c = 0; c < `OPL_CH_PER_BANK; c++) begin
                    regs[b][c] <= '0;
                end
            end
        end else if (hit) begin
            regs[reg_wr.bank][ch_off[3:0]] <= '{
                cnt:   reg_wr.data[0],
                pan_l: reg_wr.data[4],
                pan_r: reg_wr.data[5]
            };
        end
    end

    // unused channel slots read as silent
    assign cfg = (cfg_ch < `OPL_CH_PER_BANK) ? regs[cfg_bank][cfg_ch] : '0;

endmodule

/* verilog/channel_mixer.sv */
// Channel mixer FSM, combines operator pairs per channel, pans, accumulates and sends a stereo sample
`timescale 1ns/10ps
`include "opl_consts.svh"

module channel_mixer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  ops_done,
    output logic                  mixer_busy,
    output logic                  rd_en,
    output opl_pkg::bank_t        rd_bank,
    output opl_pkg::op_idx_t      rd_addr,
    input  opl_pkg::op_out_t      rd_data,
    output opl_pkg::bank_t        cfg_bank,
    output opl_pkg::ch_idx_t      cfg_ch,
    input  opl_pkg::channel_cfg_t cfg,
    output logic                  sample_req,
    input  logic                  sample_ack,
    output opl_pkg::stereo_t      sample
);
    localparam opl_pkg::acc_t ACC_MAX = (1 <<< (`OPL_SAMPLE_WIDTH - 1)) - 1;
    localparam opl_pkg::acc_t ACC_MIN = -(1 <<< (`OPL_SAMPLE_WIDTH - 1));

    opl_pkg::mixer_state_t state;
    opl_pkg::bank_t        bank;
    opl_pkg::ch_idx_t      ch;
    opl_pkg::op_out_t      op_second;    // held while the first operator is read
    opl_pkg::acc_t         acc_l;
    opl_pkg::acc_t         acc_r;
    opl_pkg::op_idx_t      op_first;
    opl_pkg::acc_t         chan_val;

    function automatic opl_pkg::sample_t clamp(opl_pkg::acc_t a);
        if (a > ACC_MAX)
            return opl_pkg::sample_t'(ACC_MAX);
        else if (a < ACC_MIN)
            return opl_pkg::sample_t'(ACC_MIN);
        else
            return opl_pkg::sample_t'(a);
    endfunction

    // channel c uses operators (c/3)*6 + c%3 and that plus 3
    assign op_first = {1'b0, ch / 4'd3} * 5'd6 + {1'b0, ch % 4'd3};

    assign rd_en   = (state == opl_pkg::READ_SECOND) || (state == opl_pkg::READ_FIRST);
    assign rd_bank = bank;
    assign rd_addr = (state == opl_pkg::READ_SECOND) ? op_first + 5'd3 : op_first;

    assign cfg_bank = bank;
    assign cfg_ch   = ch;

    // rd_data holds the first operator during ACCUMULATE
    assign chan_val = cfg.cnt ? opl_pkg::acc_t'(rd_data) + opl_pkg::acc_t'(op_second)
                              : opl_pkg::acc_t'(op_second);

    assign mixer_busy = ops_done || (state != opl_pkg::IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= opl_pkg::IDLE;
            sample_req <= 1'b0;
            bank       <= 1'b0;
            ch         <= '0;
        end else begin
            case (state)
                opl_pkg::IDLE: begin
                    acc_l <= '0;
                    acc_r <= '0;
                    bank  <= 1'b0;
                    ch    <= '0;
                    if (ops_done)
                        state <= opl_pkg::READ_SECOND;
                end
                opl_pkg::READ_SECOND: begin
                    state <= opl_pkg::READ_FIRST;
                end
                opl_pkg::READ_FIRST: begin
                    op_second <= rd_data;
                    state     <= opl_pkg::ACCUMULATE;
                end
                opl_pkg::ACCUMULATE: begin
                    if (cfg.pan_l)
                        acc_l <= acc_l + chan_val;
                    if (cfg.pan_r)
                        acc_r <= acc_r + chan_val;
                    if (ch == opl_pkg::ch_idx_t'(`OPL_CH_PER_BANK - 1)) begin
                        ch <= '0;
                        if (bank) begin
                            state <= opl_pkg::CLAMP;
                        end else begin
                            bank  <= 1'b1;
                            state <= opl_pkg::READ_SECOND;
                        end
                    end else begin
                        ch    <= ch + 4'd1;
                        state <= opl_pkg::READ_SECOND;
                    end
                end
                opl_pkg::CLAMP: begin
                    sample.left  <= clamp(acc_l);
                    sample.right <= clamp(acc_r);
                    sample_req   <= 1'b1;
                    state        <= opl_pkg::SEND;
                end
                opl_pkg::SEND: begin
                    if (sample_ack) begin
                        sample_req <= 1'b0;
                        state      <= opl_pkg::WAIT_ACK_LOW;
                    end
                end
                opl_pkg::WAIT_ACK_LOW: begin
                    if (!sample_ack)
                        state <= opl_pkg::IDLE;    // releases operator input
                end
                default: begin
                    state <= opl_pkg::IDLE;
                end
            endcase
        end
    end

    // sample may not change under an open request
    a_sample_stable: assert property (@(posedge clk) disable iff (rst)
        sample_req && $past(sample_req) |-> $stable(sample));

endmodule

/* verilog/opl_channels_top.sv */
// OPL channel stage top, ties operator capture, operator memory, channel registers and mixer
`timescale 1ns/10ps

module opl_channels_top (
    input  logic                clk,
    input  logic                rst,
    input  opl_pkg::reg_wr_t    reg_wr,
    input  logic                op_req,
    input  opl_pkg::op_result_t op_result,
    output logic                op_ack,
    output logic                sample_req,
    input  logic                sample_ack,
    output opl_pkg::stereo_t    sample
);
    logic                  mem_we;
    opl_pkg::bank_t        mem_bank;
    opl_pkg::op_idx_t      mem_addr;
    opl_pkg::op_out_t      mem_wdata;
    logic                  ops_done;
    logic                  mixer_busy;    // back-pressure on operator input
    logic                  rd_en;
    opl_pkg::bank_t        rd_bank;
    opl_pkg::op_idx_t      rd_addr;
    opl_pkg::op_out_t      rd_data;
    opl_pkg::bank_t        cfg_bank;
    opl_pkg::ch_idx_t      cfg_ch;
    opl_pkg::channel_cfg_t cfg;

    operator_capture u_operator_capture (
        .clk        (clk),
        .rst        (rst),
        .op_req     (op_req),
        .op_result  (op_result),
        .op_ack     (op_ack),
        .mixer_busy (mixer_busy),
        .mem_we     (mem_we),
        .mem_bank   (mem_bank),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .ops_done   (ops_done)
    );

    operator_out_mem u_operator_out_mem (
        .clk   (clk),
        .we    (mem_we),
        .wbank (mem_bank),
        .waddr (mem_addr),
        .wdata (mem_wdata),
        .re    (rd_en),
        .rbank (rd_bank),
        .raddr (rd_addr),
        .rdata (rd_data)
    );

    channel_regs u_channel_regs (
        .clk      (clk),
        .rst      (rst),
        .reg_wr   (reg_wr),
        .cfg_bank (cfg_bank),
        .cfg_ch   (cfg_ch),
        .cfg      (cfg)
    );

    channel_mixer u_channel_mixer (
        .clk        (clk),
        .rst        (rst),
        .ops_done   (ops_done),
        .mixer_busy (mixer_busy),
        .rd_en      (rd_en),
        .rd_bank    (rd_bank),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .cfg_bank   (cfg_bank),
        .cfg_ch     (cfg_ch),
        .cfg        (cfg),
        .sample_req (sample_req),
        .sample_ack (sample_ack),
        .sample     (sample)
    );

endmodule

/* verification/tb_opl_channels.sv */
// OPL channel stage testbench, drives operator frames and register writes and checks each sample
`timescale 1ns/10ps
`include "opl_consts.svh"

module tb_opl_channels;
    localparam int TIMEOUT = 2000;    // cycles per wait
    localparam int OP_MAX  = (1 << (`OPL_OP_WIDTH - 1)) - 1;
    localparam int OP_MIN  = -OP_MAX - 1;
    localparam int S_MAX   = (1 << (`OPL_SAMPLE_WIDTH - 1)) - 1;
    localparam int S_MIN   = -S_MAX - 1;

    logic                  clk;
    logic                  rst;
    opl_pkg::reg_wr_t      reg_wr;
    logic                  op_req;
    opl_pkg::op_result_t   op_result;
    logic                  op_ack;
    logic                  sample_req;
    logic                  sample_ack;
    opl_pkg::stereo_t      sample;

    opl_pkg::channel_cfg_t cfg_copy [`OPL_NUM_BANKS][`OPL_CH_PER_BANK];
    int                    op_val [`OPL_NUM_BANKS][`OPL_OP_PER_BANK];
    opl_pkg::stereo_t      exp_q[$];    // one entry per frame sent
    opl_pkg::stereo_t      exp_s;
    opl_pkg::stereo_t      last_sample;
    int unsigned           rng_state = 97718;
    int                    errors = 0;
    int                    checks = 0;
    bit                    req_seen = 1'b0;
    bit                    sample_done;

    opl_channels_top u_opl_channels_top (
        .clk        (clk),
        .rst        (rst),
        .reg_wr     (reg_wr),
        .op_req     (op_req),
        .op_result  (op_result),
        .op_ack     (op_ack),
        .sample_req (sample_req),
        .sample_ack (sample_ack),
        .sample     (sample)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic int unsigned next_random();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state >> 8;    // low bits of the LCG repeat too soon
    endfunction

    // expected stereo sample from the configuration and operator copies
    function automatic opl_pkg::stereo_t ref_mix();
        int               l;
        int               r;
        int               first;
        int               v;
        opl_pkg::stereo_t s;
        l = 0;
        r = 0;
        for (int b = 0; b < `OPL_NUM_BANKS; b++) begin
            for (int c = 0; c < `OPL_CH_PER_BANK; c++) begin
                first = (c / 3) * 6 + c % 3;
                v = cfg_copy[b][c].cnt ? op_val[b][first] + op_val[b][first + 3]
                                       : op_val[b][first + 3];
                if (cfg_copy[b][c].pan_l)
                    l += v;
                if (cfg_copy[b][c].pan_r)
                    r += v;
            end
        end
        l = (l > S_MAX) ? S_MAX : (l < S_MIN) ? S_MIN : l;
        r = (r > S_MAX) ? S_MAX : (r < S_MIN) ? S_MIN : r;
        s.left  = opl_pkg::sample_t'(l);
        s.right = opl_pkg::sample_t'(r);
        return s;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] expv);
        checks++;
        if (got !== expv) begin
            errors++;
            $display("Error: %s is 0x%h, expected 0x%h", name, got, expv);
        end
    endtask

    function automatic logic watched(input bit on_sample);
        return on_sample ? sample_req : op_ack;
    endfunction

    task automatic wait_level(input bit on_sample, input logic level, input string what);
        int n;
        n = 0;
        do begin
            @(negedge clk);    // outputs settled mid-cycle
            n++;
        end while (watched(on_sample) != level && n < TIMEOUT);
        if (watched(on_sample) != level) begin
            $display("Timeout after %0d cycles waiting for %s", TIMEOUT, what);
            $display("Checks failed");
            $finish;
        end
    endtask

    task automatic write_cfg(input int b, input int c, input bit cnt, input bit pl, input bit pr);
        @(posedge clk);
        reg_wr <= {1'b1, 1'(b), 8'(`OPL_REG_CH_BASE + c), 2'b00, pr, pl, 3'b000, cnt};
        @(posedge clk);
        reg_wr <= '0;
        cfg_copy[b][c] = {cnt, pl, pr};
    endtask

    task automatic send_op(input int b, input int idx, input int val);
        @(posedge clk);
        op_result <= {1'(b), 5'(idx), opl_pkg::op_out_t'(val)};
        op_req    <= 1'b1;
        wait_level(1'b0, 1'b1, "op_ack to rise");
        @(posedge clk);
        op_req <= 1'b0;
        wait_level(1'b0, 1'b0, "op_ack to fall");
    endtask

    // mode 0 random, 1 all at the positive limit, 2 all at the negative limit
    task automatic set_ops(input int mode);
        for (int b = 0; b < `OPL_NUM_BANKS; b++) begin
            for (int i = 0; i < `OPL_OP_PER_BANK; i++) begin
                op_val[b][i] = (mode == 1) ? OP_MAX : (mode == 2) ? OP_MIN
                             : int'(next_random() % 8192) + OP_MIN;
            end
        end
    endtask

    task automatic send_frame(input bit shuffle, input bit check_hold);
        int order [`OPL_NUM_BANKS * `OPL_OP_PER_BANK];
        int j;
        int t;
        for (int i = 0; i < $size(order); i++)
            order[i] = i;
        if (shuffle) begin
            for (int i = $size(order) - 1; i > 0; i--) begin
                j = int'(next_random() % (i + 1));
                t = order[i];
                order[i] = order[j];
                order[j] = t;
            end
        end
        for (int i = 0; i < $size(order); i++) begin
            send_op(order[i] / `OPL_OP_PER_BANK, order[i] % `OPL_OP_PER_BANK,
                    op_val[order[i] / `OPL_OP_PER_BANK][order[i] % `OPL_OP_PER_BANK]);
            if (check_hold && i == 0)
                check_val("sample_done at first op_ack", 32'(sample_done), 32'd1);
        end
        exp_q.push_back(ref_mix());
    endtask

    task automatic get_sample(input int delay);
        wait_level(1'b1, 1'b1, "sample_req to rise");
        last_sample = sample;
        repeat (delay) @(posedge clk);
        @(posedge clk);
        sample_ack <= 1'b1;
        wait_level(1'b1, 1'b0, "sample_req to fall");
        @(posedge clk);
        sample_ack <= 1'b0;
    endtask

    task automatic end_test(input int num, input string name);
        $display("Test %0d %s finished, %0d checks, %0d errors so far", num, name, checks, errors);
    endtask

    // compares each new sample with the oldest outstanding expectation
    always @(negedge clk) begin
        if (!rst && sample_req && !req_seen) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("A sample arrived with no frame outstanding");
            end else begin
                exp_s = exp_q.pop_front();
                check_val("sample.left", 32'(sample.left), 32'(exp_s.left));
                check_val("sample.right", 32'(sample.right), 32'(exp_s.right));
            end
        end
        req_seen = sample_req;
    end

    initial begin
        int unsigned r;
        rst        = 1'b1;
        reg_wr     = '0;
        op_req     = 1'b0;
        op_result  = '0;
        sample_ack = 1'b0;
        for (int b = 0; b < `OPL_NUM_BANKS; b++)
            for (int c = 0; c < `OPL_CH_PER_BANK; c++)
                cfg_copy[b][c] = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        repeat (5) begin
            @(negedge clk);
            check_val("op_ack", 32'(op_ack), 32'd0);
            check_val("sample_req", 32'(sample_req), 32'd0);
        end
        set_ops(0);
        send_frame(1'b0, 1'b0);
        get_sample(0);
        end_test(1, "reset and silent frame");

        write_cfg(0, 4, 1'b1, 1'b1, 1'b1);
        write_cfg(1, 7, 1'b0, 1'b1, 1'b0);
        set_ops(0);
        send_frame(1'b0, 1'b0);
        get_sample(2);
        end_test(2, "connection");

        write_cfg(0, 0, 1'b1, 1'b1, 1'b0);    // left only
        write_cfg(0, 1, 1'b0, 1'b0, 1'b1);    // right only
        write_cfg(1, 2, 1'b1, 1'b0, 1'b0);    // muted
        write_cfg(1, 5, 1'b1, 1'b0, 1'b1);
        set_ops(0);
        send_frame(1'b0, 1'b0);
        get_sample(1);
        end_test(3, "panning");

        for (int b = 0; b < `OPL_NUM_BANKS; b++)
            for (int c = 0; c < `OPL_CH_PER_BANK; c++)
                write_cfg(b, c, 1'b1, 1'b1, 1'b1);
        set_ops(1);
        send_frame(1'b0, 1'b0);
        get_sample(0);
        check_val("sample.left", 32'(last_sample.left), 32'(S_MAX));
        check_val("sample.right", 32'(last_sample.right), 32'(S_MAX));
        set_ops(2);
        send_frame(1'b0, 1'b0);
        get_sample(0);
        check_val("sample.left", 32'(last_sample.left), 32'(S_MIN));
        check_val("sample.right", 32'(last_sample.right), 32'(S_MIN));
        end_test(4, "saturation");

        for (int f = 0; f < 8; f++) begin
            for (int b = 0; b < `OPL_NUM_BANKS; b++) begin
                for (int c = 0; c < `OPL_CH_PER_BANK; c++) begin
                    r = next_random();
                    write_cfg(b, c, r[0], r[1], r[2]);
                end
            end
            set_ops(0);
            send_frame(1'b1, 1'b0);
            get_sample(int'(next_random() % 8));
        end
        end_test(5, "random frames");

        set_ops(0);
        send_frame(1'b1, 1'b0);
        set_ops(0);    // next frame is offered while the first one mixes
        sample_done = 1'b0;
        fork
            begin
                get_sample(150);
                sample_done = 1'b1;
            end
            send_frame(1'b1, 1'b1);
        join
        get_sample(0);
        end_test(6, "back-pressure");

        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d expected samples never arrived", exp_q.size());
        end
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

/* all.f */
+incdir+include
verilog/opl_pkg.sv
verilog/operator_capture.sv
verilog/operator_out_mem.sv
verilog/channel_regs.sv
verilog/channel_mixer.sv
verilog/opl_channels_top.sv
verification/tb_opl_channels.sv

/* run.sh */
#!/bin/sh
# Build the OPL channel stage testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_opl_channels \
    -f all.f -o tb_opl_channels
./obj_dir/tb_opl_channels > sim.log
cat sim.log

if grep -qx "All checks passed" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
